/* build.f */
+incdir+include
source/vgaPkg.sv
source/drawCmdReceiver.sv
source/pixelStore.sv
source/vgaController.sv
source/videoOutput.sv
source/top.sv
test/tbClock.sv
test/tbTop.sv

/* Bender.yml */
package:
  name: vga_draw

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/vgaPkg.sv
      - source/drawCmdReceiver.sv
      - source/pixelStore.sv
      - source/vgaController.sv
      - source/videoOutput.sv
      - source/top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tbClock.sv
      - test/tbTop.sv

/* test/tbTop.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vga_params.svh"

module tbTop import vgaPkg::*; ();

  localparam int hTotal = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int vTotal = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int frameCycles = hTotal * vTotal;
  // clear takes one cycle per cell plus a few
  localparam int ackLimit = 2 * `GRID_W * `GRID_H;

  logic       clk;
  logic       rst;
  logic       req;
  drawOp      op;
  cellX       cellXIn;
  cellY       cellYIn;
  colorCode   colorIn;
  logic       ack;
  logic       hsync;
  logic       vsync;
  logic       blank_b;
  logic [3:0] rBlanked;
  logic [3:0] gBlanked;
  logic [3:0] bBlanked;

  integer seed = 32'h53f46280;

  // expected color of each cell by row and column
  colorCode expCell [`GRID_H][`GRID_W];

  tbClock clockGen (
    .clk,
    .rst
  );

  top dut_i (
    .clk,
    .rst,
    .req,
    .op,
    .cellXIn,
    .cellYIn,
    .colorIn,
    .ack,
    .hsync,
    .vsync,
    .blank_b,
    .rBlanked,
    .gBlanked,
    .bBlanked
  );

  task automatic abortRun(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkLevel(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
      abortRun("single-bit mismatch");
    end
  endtask

  task automatic checkCount(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
      abortRun("count mismatch");
    end
  endtask

  // each color bit is full scale or off
  task automatic checkColor(input string name, input colorCode exp,
                            input logic [3:0] r, input logic [3:0] g, input logic [3:0] b);
    logic [11:0] expRgb;
    expRgb = {exp[2] ? 4'hF : 4'h0, exp[1] ? 4'hF : 4'h0, exp[0] ? 4'hF : 4'h0};
    if ({r, g, b} !== expRgb) begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, expRgb, {r, g, b});
      abortRun("color mismatch");
    end
  endtask

  // four-phase exchange with latency counted in rising edges
  task automatic sendCmd(input drawOp cmd, input cellX x, input cellY y,
                         input colorCode color, input int holdCycles, output int latency);
    int   n;
    logic seen;
    checkLevel("ack before req", 1'b0, ack);
    @(posedge clk);
    #1;
    op = cmd;
    cellXIn = x;
    cellYIn = y;
    colorIn = color;
    // data settles one cycle ahead of req
    @(posedge clk);
    #1 req = 1'b1;
    n = 0;
    seen = 1'b0;
    while (!seen) begin
      @(posedge clk);
      n++;
      @(negedge clk);
      seen = ack;
      if (!seen && n >= ackLimit) abortRun("no ack from the receiver");
    end
    latency = n;
    // ack must stay up while req is high
    repeat (holdCycles) begin
      @(negedge clk);
      checkLevel("ack while req high", 1'b1, ack);
    end
    @(posedge clk);
    #1 req = 1'b0;
    n = 0;
    while (seen) begin
      @(posedge clk);
      n++;
      @(negedge clk);
      seen = ack;
      if (seen && n >= 16) abortRun("ack did not fall after req dropped");
    end
    checkCount("ack fall latency", 1, n);
  endtask

  // paint or erase updates the model only for on-grid cells
  task automatic writeCell(input drawOp cmd, input cellX x, input cellY y, input colorCode color);
    int latency;
    sendCmd(cmd, x, y, color, 0, latency);
    checkCount("write ack latency", 2, latency);
    if (x < `GRID_W && y < `GRID_H) expCell[y][x] = (cmd == OP_PAINT) ? color : 3'b000;
  endtask

  // one frame between vsync falls with coordinates rebuilt from the outputs
  task automatic scanFrame(input bit checkPixels);
    int   waited;
    int   cycles;
    int   lines;
    int   pixCount;
    int   vsyncLow;
    int   hsyncLow;
    int   lastHFall;
    logic prevV;
    logic prevH;
    logic prevBlank;
    logic found;
    found = 1'b0;
    waited = 0;
    @(negedge clk);
    prevV = vsync;
    while (!found) begin
      @(negedge clk);
      waited++;
      found = prevV && !vsync;
      prevV = vsync;
      if (!found && waited > 2 * frameCycles) abortRun("vsync never fell");
    end
    cycles = 0;
    lines = 0;
    pixCount = 0;
    vsyncLow = 0;
    hsyncLow = 0;
    lastHFall = -1;
    prevH = hsync;
    prevBlank = 1'b0;
    found = 1'b0;
    while (!found) begin
      if (blank_b) begin
        if (!prevBlank) pixCount = 0;
        if (lines >= `V_ACTIVE || pixCount >= `H_ACTIVE) begin
          abortRun("active pixel outside the 640 by 480 area");
        end
        if (checkPixels) begin
          checkColor("pixel rgb", expCell[lines >> `CELL_SHIFT][pixCount >> `CELL_SHIFT],
                     rBlanked, gBlanked, bBlanked);
        end
        pixCount++;
      end else begin
        checkColor("blanked rgb", 3'b000, rBlanked, gBlanked, bBlanked);
        if (prevBlank) begin
          checkCount("active pixels per line", `H_ACTIVE, pixCount);
          lines++;
        end
      end
      if (!vsync) vsyncLow++;
      // hsync period measured between falls and width up to the rise
      if (prevH && !hsync) begin
        if (lastHFall >= 0) checkCount("hsync period", hTotal, cycles - lastHFall);
        lastHFall = cycles;
        hsyncLow = 0;
      end
      if (!hsync) hsyncLow++;
      if (!prevH && hsync && lastHFall >= 0) checkCount("hsync low width", `H_SYNC, hsyncLow);
      prevH = hsync;
      prevBlank = blank_b;
      prevV = vsync;
      @(negedge clk);
      cycles++;
      found = prevV && !vsync;
      if (!found && cycles > frameCycles + hTotal) abortRun("frame did not end");
    end
    checkCount("cycles per frame", frameCycles, cycles);
    checkCount("active lines per frame", `V_ACTIVE, lines);
    checkCount("vsync low cycles", `V_SYNC * hTotal, vsyncLow);
  endtask

  // sample at least one falling edge so reset is seen asserted first
  task automatic waitForReset;
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (rst && n > 100) abortRun("reset never released");
    end while (rst);
  endtask

  task automatic resetValues;
    checkLevel("ack", 1'b0, ack);
    checkLevel("hsync", 1'b1, hsync);
    checkLevel("vsync", 1'b1, vsync);
    checkLevel("blank_b", 1'b0, blank_b);
    checkColor("rgb after reset", 3'b000, rBlanked, gBlanked, bBlanked);
  endtask

  // store is unknown here, so timing and blanking only
  task automatic rasterTiming;
    scanFrame(1'b0);
  endtask

  task automatic clearThenPaint;
    int       latency;
    int       i;
    int       r;
    int       k;
    cellX     x;
    cellY     y;
    colorCode c;
    sendCmd(OP_CLEAR, '0, '0, '0, 0, latency);
    if (latency < `GRID_W * `GRID_H) abortRun("clear acked before sweeping every cell");
    for (r = 0; r < `GRID_H; r++) begin
      for (k = 0; k < `GRID_W; k++) begin
        expCell[r][k] = 3'b000;
      end
    end
    for (i = 0; i < 12; i++) begin
      x = cellX'($unsigned($random(seed)) % `GRID_W);
      y = cellY'($unsigned($random(seed)) % `GRID_H);
      c = colorCode'($unsigned($random(seed)) % 8);
      writeCell(OP_PAINT, x, y, c);
    end
    scanFrame(1'b1);
  endtask

  // center erased while its four neighbors keep their colors
  task automatic eraseCenter;
    writeCell(OP_PAINT, 7'd19, 6'd30, 3'b001);
    writeCell(OP_PAINT, 7'd21, 6'd30, 3'b010);
    writeCell(OP_PAINT, 7'd20, 6'd29, 3'b100);
    writeCell(OP_PAINT, 7'd20, 6'd31, 3'b111);
    writeCell(OP_PAINT, 7'd20, 6'd30, 3'b110);
    scanFrame(1'b1);
    writeCell(OP_ERASE, 7'd20, 6'd30, 3'b101);
    scanFrame(1'b1);
  endtask

  task automatic offGridPaint;
    writeCell(OP_PAINT, 7'd80, 6'd5, 3'b111);
    writeCell(OP_PAINT, 7'd3, 6'd60, 3'b111);
    writeCell(OP_PAINT, 7'd127, 6'd63, 3'b011);
    scanFrame(1'b1);
  endtask

  // long req hold followed by a back-to-back command
  task automatic handshakeHold;
    int latency;
    sendCmd(OP_PAINT, 7'd0, 6'd0, 3'b011, 6, latency);
    checkCount("held paint ack latency", 2, latency);
    expCell[0][0] = 3'b011;
    writeCell(OP_PAINT, 7'd79, 6'd59, 3'b101);
    scanFrame(1'b1);
  endtask

  initial begin
    req = 1'b0;
    op = OP_PAINT;
    cellXIn = '0;
    cellYIn = '0;
    colorIn = '0;
    waitForReset();
    resetValues();
    rasterTiming();
    clearThenPaint();
    eraseCenter();
    offGridPaint();
    handshakeHold();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* test/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic clk,
  output logic rst
);

  // 8 ns pixel clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset over four rising edges, released just after the last one
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

/* source/top.sv */
`timescale 1ns/1ps
`default_nettype none

module top import vgaPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       req,
  input  drawOp      op,
  input  cellX       cellXIn,
  input  cellY       cellYIn,
  input  colorCode   colorIn,
  output logic       ack,
  output logic       hsync,
  output logic       vsync,
  output logic       blank_b,
  output logic [3:0] rBlanked,
  output logic [3:0] gBlanked,
  output logic [3:0] bBlanked
);

  // receiver write port into the store
  logic     wrEn;
  cellX     wrX;
  cellY     wrY;
  colorCode wrColor;

  // raw timing, shared by store and output stage
  logic [9:0] pixX;
  logic [9:0] pixY;
  logic       hsyncRaw;
  logic       vsyncRaw;
  logic       activeRaw;

  // store read data, one cycle behind pixX/pixY
  colorCode rdColor;

  // host commands in
  drawCmdReceiver drawCmdReceiver (
    .clk,
    .rst,
    .req,
    .op,
    .cellXIn,
    .cellYIn,
    .colorIn,
    .ack,
    .wrEn,
    .wrX,
    .wrY,
    .wrColor
  );

  pixelStore pixelStore (
    .clk,
    .wrEn,
    .wrX,
    .wrY,
    .wrColor,
    .pixX,
    .pixY,
    .rdColor
  );

  // 800x525 raster on the 25.175 MHz clock
  vgaController vgaController (
    .clk,
    .rst,
    .pixX,
    .pixY,
    .hsyncRaw,
    .vsyncRaw,
    .activeRaw
  );

  // to monitor and video DAC
  videoOutput videoOutput (
    .clk,
    .rst,
    .hsyncRaw,
    .vsyncRaw,
    .activeRaw,
    .rdColor,
    .hsync,
    .vsync,
    .blank_b,
    .rBlanked,
    .gBlanked,
    .bBlanked
  );

endmodule

`default_nettype wire

/* source/videoOutput.sv */
`timescale 1ns/1ps
`default_nettype none

module videoOutput import vgaPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       hsyncRaw,
  input  logic       vsyncRaw,
  input  logic       activeRaw,
  input  colorCode   rdColor,
  output logic       hsync,
  output logic       vsync,
  output logic       blank_b,
  output logic [3:0] rBlanked,
  output logic [3:0] gBlanked,
  output logic [3:0] bBlanked
);

  // timing delayed one cycle to line up with the store read
  logic hsyncQ;
  logic vsyncQ;
  logic activeQ;

  always_ff @(posedge clk) begin
    if (rst) begin
      hsyncQ <= 1'b1;
      vsyncQ <= 1'b1;
      activeQ <= 1'b0;
    end else begin
      hsyncQ <= hsyncRaw;
      vsyncQ <= vsyncRaw;
      activeQ <= activeRaw;
    end
  end

  // output register, each color bit is full scale or off
  always_ff @(posedge clk) begin
    if (rst) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      blank_b <= 1'b0;
      rBlanked <= '0;
      gBlanked <= '0;
      bBlanked <= '0;
    end else begin
      hsync <= hsyncQ;
      vsync <= vsyncQ;
      blank_b <= activeQ;
      // colors forced dark outside the active region
      rBlanked <= activeQ ? {4{rdColor[2]}} : 4'h0;
      gBlanked <= activeQ ? {4{rdColor[1]}} : 4'h0;
      bBlanked <= activeQ ? {4{rdColor[0]}} : 4'h0;
    end
  end

endmodule

`default_nettype wire

/* source/vgaController.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vga_params.svh"

module vgaController (
  input  logic       clk,
  input  logic       rst,
  output logic [9:0] pixX,
  output logic [9:0] pixY,
  output logic       hsyncRaw,
  output logic       vsyncRaw,
  output logic       activeRaw
);

  // 800 clocks per line
  localparam int hTotal = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  // 525 lines per frame
  localparam int vTotal = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int hSyncStart = `H_ACTIVE + `H_FRONT;
  localparam int hSyncEnd = hSyncStart + `H_SYNC;
  localparam int vSyncStart = `V_ACTIVE + `V_FRONT;
  localparam int vSyncEnd = vSyncStart + `V_SYNC;

  logic [9:0] hCount;
  logic [9:0] vCount;
  logic       hLast;
  logic       vLast;

  assign hLast = (hCount == 10'(hTotal - 1));
  assign vLast = (vCount == 10'(vTotal - 1));

  // horizontal wrap steps the line counter
  always_ff @(posedge clk) begin
    if (rst) begin
      hCount <= '0;
      vCount <= '0;
    end else if (hLast) begin
      hCount <= '0;
      vCount <= vLast ? '0 : vCount + 1'b1;
    end else begin
      hCount <= hCount + 1'b1;
    end
  end

  assign pixX = hCount;
  assign pixY = vCount;

  // sync pulses active low
  assign hsyncRaw = ~((hCount >= 10'(hSyncStart)) && (hCount < 10'(hSyncEnd)));
  assign vsyncRaw = ~((vCount >= 10'(vSyncStart)) && (vCount < 10'(vSyncEnd)));

  // visible 640x480 region starts at count 0
  assign activeRaw = (hCount < 10'(`H_ACTIVE)) && (vCount < 10'(`V_ACTIVE));

endmodule

`default_nettype wire

/* source/pixelStore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vga_params.svh"

module pixelStore import vgaPkg::*; (
  input  logic       clk,
  input  logic       wrEn,
  input  cellX       wrX,
  input  cellY       wrY,
  input  colorCode   wrColor,
  input  logic [9:0] pixX,
  input  logic [9:0] pixY,
  output colorCode   rdColor
);

  localparam int cellCount = `GRID_W * `GRID_H;
  localparam int addrW = $clog2(cellCount);

  // one color code per cell
  colorCode mem [cellCount];

  cellX rdX;
  cellY rdY;
  logic [addrW-1:0] wrAddr;
  logic [addrW-1:0] rdAddr;

  // row-major cell index
  function automatic logic [addrW-1:0] cellAddr(input cellX x, input cellY y);
    return addrW'(y) * addrW'(`GRID_W) + addrW'(x);
  endfunction

  // pixel position down to cell position
  // wraps during blanking, output stage masks that
  assign rdX = cellX'(pixX >> `CELL_SHIFT);
  assign rdY = cellY'(pixY >> `CELL_SHIFT);

  assign wrAddr = cellAddr(wrX, wrY);
  assign rdAddr = cellAddr(rdX, rdY);

  // write port from the command receiver
  always_ff @(posedge clk) begin
    if (wrEn) mem[wrAddr] <= wrColor;
  end

  // registered read, one cycle after the pixel address
  always_ff @(posedge clk) begin
    if (rdAddr < addrW'(cellCount)) rdColor <= mem[rdAddr];
  end

endmodule

`default_nettype wire

/* source/drawCmdReceiver.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vga_params.svh"

module drawCmdReceiver import vgaPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     req,
  input  drawOp    op,
  input  cellX     cellXIn,
  input  cellY     cellYIn,
  input  colorCode colorIn,
  output logic     ack,
  output logic     wrEn,
  output cellX     wrX,
  output cellY     wrY,
  output colorCode wrColor
);

  rxState   state;
  logic     reqQ;
  logic     reqRise;
  // command latched at req rising edge
  drawOp    cmdOp;
  cellX     cmdX;
  cellY     cmdY;
  colorCode cmdColor;
  // clear sweep position
  cellX     clrX;
  cellY     clrY;
  logic     clrRowEnd;
  logic     clrLast;
  logic     onGrid;

  assign reqRise = req & ~reqQ;

  // off-grid paint or erase is acked but never written
  assign onGrid = (cmdX < cellX'(`GRID_W)) && (cmdY < cellY'(`GRID_H));

  assign clrRowEnd = (clrX == cellX'(`GRID_W - 1));
  assign clrLast = clrRowEnd && (clrY == cellY'(`GRID_H - 1));

  // ack held for as long as the fsm waits for req low
  assign ack = (state == S_ACK);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      reqQ <= 1'b0;
      clrX <= '0;
      clrY <= '0;
    end else begin
      reqQ <= req;
      case (state)
        S_IDLE: begin
          if (reqRise) begin
            clrX <= '0;
            clrY <= '0;
            state <= (op == OP_CLEAR) ? S_CLEAR : S_WRITE;
          end
        end
        // single write strobe, ack on the next cycle
        S_WRITE: state <= S_ACK;
        // one cell per cycle, row by row
        S_CLEAR: begin
          if (clrLast) begin
            state <= S_ACK;
          end else if (clrRowEnd) begin
            clrX <= '0;
            clrY <= clrY + 1'b1;
          end else begin
            clrX <= clrX + 1'b1;
          end
        end
        S_ACK: begin
          if (!req) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (state == S_IDLE && reqRise) begin
      cmdOp <= op;
      cmdX <= cellXIn;
      cmdY <= cellYIn;
      cmdColor <= colorIn;
    end
  end

  // store write port, erase writes code 0
  always_comb begin
    wrEn = 1'b0;
    wrX = cmdX;
    wrY = cmdY;
    wrColor = (cmdOp == OP_PAINT) ? cmdColor : '0;
    case (state)
      S_WRITE: wrEn = onGrid;
      S_CLEAR: begin
        wrEn = 1'b1;
        wrX = clrX;
        wrY = clrY;
        wrColor = '0;
      end
      default: wrEn = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* source/vgaPkg.sv */
`default_nettype none

package vgaPkg;

  // host command opcodes
  typedef enum logic [1:0] {
    OP_PAINT,
    OP_ERASE,
    OP_CLEAR
  } drawOp;

  // command receiver states
  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_CLEAR,
    S_ACK
  } rxState;

  // bit 2 red, bit 1 green, bit 0 blue
  typedef logic [2:0] colorCode;

  // cell coordinates, 0..79 across and 0..59 down
  typedef logic [6:0] cellX;
  typedef logic [5:0] cellY;

endpackage

`default_nettype wire

/* include/vga_params.svh */
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// 640x480 at 60 Hz, horizontal timing in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

// cells are 8x8 pixels
`define CELL_SHIFT 3

// cell grid, 640/8 across and 480/8 down
`define GRID_W 80
`define GRID_H 60

`endif
